// ==== hdl/tri_pkg.sv ====
`default_nettype none

package tri_pkg;

    localparam int NUM_TRIANGLE  = 512;
    localparam int TRI_ID_W      = $clog2(NUM_TRIANGLE);
    localparam int NUM_VERTEX    = 2048;
    localparam int VERTEX_ADDR_W = $clog2(NUM_VERTEX);

    // x in the low word
    typedef struct packed {
        logic [31:0] z;
        logic [31:0] y;
        logic [31:0] x;
    } vertex_t;

    typedef struct packed {
        logic [31:0] sid;
        logic [31:0] v2;
        logic [31:0] v1;
        logic [31:0] v0;
    } index_rec_t;

    typedef struct packed {
        logic [31:0] flag;
        vertex_t     pos;
    } vertex_rec_t;

    // top 32 bits are sid or flag, zero closes a section
    typedef union packed {
        index_rec_t  idx;
        vertex_rec_t vtx;
    } load_word_u;

    typedef struct packed {
        logic                we;
        logic [TRI_ID_W-1:0] addr;
        index_rec_t          rec;
    } idx_wr_t;

    typedef struct packed {
        logic                     we;
        logic [VERTEX_ADDR_W-1:0] addr;
        vertex_t                  pos;
    } vtx_wr_t;

    typedef struct packed {
        logic                req;
        logic [TRI_ID_W-1:0] id;
    } rd_req_t;

    typedef struct packed {
        logic [31:0] sid;
        vertex_t     v2;
        vertex_t     v1;
        vertex_t     v0;
    } tri_out_t;

    // slot_en bits: 0..2 vertex slots, 3 sid
    typedef struct packed {
        logic [3:0]  slot_en;
        vertex_t     pos;
        logic [31:0] sid;
    } capture_t;

endpackage

`default_nettype wire

// ==== hdl/single_port_ram.sv ====
`default_nettype none

module single_port_ram #(
    parameter int ADDR_WIDTH = 9,
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   we,
    input  wire  [ADDR_WIDTH-1:0] addr,
    input  wire  [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] q
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // read returns the old word on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/load_decoder.sv ====
`default_nettype none

module load_decoder (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         mc_we,
    input  wire tri_pkg::load_word_u    mc_word,
    output tri_pkg::idx_wr_t            idx_wr,
    output tri_pkg::vtx_wr_t            vtx_wr,
    output logic [tri_pkg::TRI_ID_W:0]  tri_count,
    output logic                        loading
);

    import tri_pkg::*;

    typedef enum logic [1:0] {
        SEC_IDLE,
        SEC_INDEX,
        SEC_VERTEX
    } sec_t;

    sec_t                     sec;
    load_word_u               word_q;
    logic                     idx_we_q;
    logic                     vtx_we_q;
    logic [TRI_ID_W-1:0]      idx_addr_q;
    logic [VERTEX_ADDR_W-1:0] vtx_addr_q;
    logic [TRI_ID_W:0]        slot_cnt;
    logic [TRI_ID_W:0]        slot_base;
    logic [VERTEX_ADDR_W-1:0] vtx_cnt;
    logic                     top_zero;

    // sid and flag sit in the same bits
    assign top_zero  = (mc_word.idx.sid == '0);
    // a strobe after the end marker restarts at slot 0
    assign slot_base = (sec == SEC_IDLE) ? '0 : slot_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sec       <= SEC_IDLE;
            idx_we_q  <= 1'b0;
            vtx_we_q  <= 1'b0;
            slot_cnt  <= '0;
            vtx_cnt   <= '0;
            tri_count <= '0;
            loading   <= 1'b0;
        end else begin
            idx_we_q <= 1'b0;
            vtx_we_q <= 1'b0;
            if (mc_we) begin
                case (sec)
                    SEC_VERTEX: begin
                        if (top_zero) begin
                            sec     <= SEC_IDLE;
                            loading <= 1'b0;
                        end else begin
                            vtx_we_q <= 1'b1;
                            vtx_cnt  <= vtx_cnt + 1'b1;
                        end
                    end
                    default: begin
                        loading <= 1'b1;
                        if (top_zero) begin
                            // index section closed, slot count is the triangle count
                            sec       <= SEC_VERTEX;
                            tri_count <= slot_base;
                            vtx_cnt   <= '0;
                        end else begin
                            sec      <= SEC_INDEX;
                            idx_we_q <= 1'b1;
                            slot_cnt <= slot_base + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mc_we) begin
            word_q     <= mc_word;
            idx_addr_q <= slot_base[TRI_ID_W-1:0];
            vtx_addr_q <= vtx_cnt;
        end
    end

    // same registered word, seen as index or vertex record
    assign idx_wr.we   = idx_we_q;
    assign idx_wr.addr = idx_addr_q;
    assign idx_wr.rec  = word_q.idx;
    assign vtx_wr.we   = vtx_we_q;
    assign vtx_wr.addr = vtx_addr_q;
    assign vtx_wr.pos  = word_q.vtx.pos;

endmodule

`default_nettype wire

// ==== hdl/triangle_fetch.sv ====
`default_nettype none

module triangle_fetch (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire tri_pkg::idx_wr_t       idx_wr,
    input  wire tri_pkg::vtx_wr_t       vtx_wr,
    input  wire                         loading,
    input  wire [tri_pkg::TRI_ID_W:0]   tri_count,
    input  wire tri_pkg::rd_req_t       rd_req,
    output tri_pkg::capture_t           capture,
    output logic                        deliver,
    output logic                        reject
);

    import tri_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_IDX,
        S_V0,
        S_V1,
        S_V2,
        S_CAP,
        S_DLV
    } seq_t;

    seq_t                     state;
    seq_t                     state_nx;
    logic [TRI_ID_W-1:0]      cur_id;
    logic [TRI_ID_W-1:0]      cur_id_nx;
    logic                     pf_valid;
    logic                     pf_valid_nx;
    logic                     prefetching;
    logic                     prefetching_nx;
    logic                     redirect;
    logic                     req_in_range;
    logic                     req_match;
    logic                     next_in_range;
    logic [TRI_ID_W:0]        next_id;
    logic [TRI_ID_W-1:0]      idx_addr;
    logic [VERTEX_ADDR_W-1:0] vtx_addr;
    logic [VERTEX_ADDR_W-1:0] vtx_rd_addr;
    index_rec_t               idx_q;
    vertex_t                  vtx_q;

    // loader owns both RAMs while a load runs
    assign idx_addr = loading ? idx_wr.addr : cur_id;
    assign vtx_addr = loading ? vtx_wr.addr : vtx_rd_addr;

    single_port_ram #(
        .ADDR_WIDTH(TRI_ID_W),
        .DATA_WIDTH($bits(index_rec_t))
    ) u_index_ram (
        .clk (clk),
        .we  (idx_wr.we),
        .addr(idx_addr),
        .data(idx_wr.rec),
        .q   (idx_q)
    );

    single_port_ram #(
        .ADDR_WIDTH(VERTEX_ADDR_W),
        .DATA_WIDTH($bits(vertex_t))
    ) u_vertex_ram (
        .clk (clk),
        .we  (vtx_wr.we),
        .addr(vtx_addr),
        .data(vtx_wr.pos),
        .q   (vtx_q)
    );

    assign req_in_range  = ({1'b0, rd_req.id} < tri_count);
    assign req_match     = (rd_req.id == cur_id);
    assign next_id       = {1'b0, cur_id} + 1'b1;
    assign next_in_range = (next_id < tri_count);

    // vertex address and capture slot follow the read step
    always_comb begin
        capture.pos     = vtx_q;
        capture.sid     = idx_q.sid;
        capture.slot_en = 4'b0000;
        vtx_rd_addr     = idx_q.v0[VERTEX_ADDR_W-1:0];
        case (state)
            S_V0: begin
                capture.slot_en = 4'b1000;
            end
            S_V1: begin
                capture.slot_en = 4'b0001;
                vtx_rd_addr     = idx_q.v1[VERTEX_ADDR_W-1:0];
            end
            S_V2: begin
                capture.slot_en = 4'b0010;
                vtx_rd_addr     = idx_q.v2[VERTEX_ADDR_W-1:0];
            end
            S_CAP: begin
                capture.slot_en = 4'b0100;
            end
            default: begin
                capture.slot_en = 4'b0000;
            end
        endcase
    end

    always_comb begin
        state_nx       = state;
        cur_id_nx      = cur_id;
        pf_valid_nx    = pf_valid;
        prefetching_nx = prefetching;
        deliver        = 1'b0;
        reject         = 1'b0;
        redirect       = 1'b0;

        case (state)
            S_IDX: state_nx = S_V0;
            S_V0:  state_nx = S_V1;
            S_V1:  state_nx = S_V2;
            S_V2:  state_nx = S_CAP;
            S_CAP: state_nx = S_DLV;
            S_DLV: begin
                if (prefetching) begin
                    // park it until someone asks for this id
                    pf_valid_nx    = 1'b1;
                    prefetching_nx = 1'b0;
                    state_nx       = S_IDLE;
                end else begin
                    deliver = 1'b1;
                end
            end
            default: state_nx = S_IDLE;
        endcase

        if (rd_req.req) begin
            if (!req_in_range) begin
                reject         = 1'b1;
                redirect       = 1'b1;
                pf_valid_nx    = 1'b0;
                prefetching_nx = 1'b0;
                state_nx       = S_IDLE;
            end else if (req_match && (pf_valid || (state == S_DLV && prefetching))) begin
                // prefetched triangle is complete in staging
                deliver = 1'b1;
            end else if (req_match && state != S_IDLE) begin
                // let the running prefetch finish and answer
                prefetching_nx = 1'b0;
            end else begin
                redirect       = 1'b1;
                cur_id_nx      = rd_req.id;
                state_nx       = S_IDX;
                pf_valid_nx    = 1'b0;
                prefetching_nx = 1'b0;
            end
        end

        // served, so walk on to the next id
        if (deliver && !redirect) begin
            pf_valid_nx = 1'b0;
            if (next_in_range) begin
                cur_id_nx      = next_id[TRI_ID_W-1:0];
                state_nx       = S_IDX;
                prefetching_nx = 1'b1;
            end else begin
                state_nx       = S_IDLE;
                prefetching_nx = 1'b0;
            end
        end

        if (loading) begin
            state_nx       = S_IDLE;
            pf_valid_nx    = 1'b0;
            prefetching_nx = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            cur_id      <= '0;
            pf_valid    <= 1'b0;
            prefetching <= 1'b0;
        end else begin
            state       <= state_nx;
            cur_id      <= cur_id_nx;
            pf_valid    <= pf_valid_nx;
            prefetching <= prefetching_nx;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_buffer.sv ====
`default_nettype none

module result_buffer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire tri_pkg::capture_t capture,
    input  wire                   deliver,
    input  wire                   reject,
    output logic                  rdy,
    output logic                  not_valid,
    output tri_pkg::tri_out_t     tri_out
);

    import tri_pkg::*;

    tri_out_t stage_q;
    tri_out_t out_q;

    // staging fills while the last answer stays on tri_out
    always_ff @(posedge clk) begin
        if (capture.slot_en[0]) begin
            stage_q.v0 <= capture.pos;
        end
        if (capture.slot_en[1]) begin
            stage_q.v1 <= capture.pos;
        end
        if (capture.slot_en[2]) begin
            stage_q.v2 <= capture.pos;
        end
        if (capture.slot_en[3]) begin
            stage_q.sid <= capture.sid;
        end
        if (deliver) begin
            out_q <= stage_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy       <= 1'b0;
            not_valid <= 1'b0;
        end else begin
            rdy       <= deliver;
            not_valid <= reject;
        end
    end

    assign tri_out = out_q;

endmodule

`default_nettype wire

// ==== hdl/triangle_store.sv ====
`default_nettype none

module triangle_store (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      mc_we,
    input  wire tri_pkg::load_word_u mc_word,
    input  wire tri_pkg::rd_req_t    rd_req,
    output logic                     rdy,
    output tri_pkg::tri_out_t        tri_out,
    output logic                     not_valid
);

    import tri_pkg::*;

    idx_wr_t           idx_wr;
    vtx_wr_t           vtx_wr;
    logic [TRI_ID_W:0] tri_count;
    logic              loading;
    capture_t          capture;
    logic              deliver;
    logic              reject;

    load_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .mc_we    (mc_we),
        .mc_word  (mc_word),
        .idx_wr   (idx_wr),
        .vtx_wr   (vtx_wr),
        .tri_count(tri_count),
        .loading  (loading)
    );

    triangle_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .idx_wr   (idx_wr),
        .vtx_wr   (vtx_wr),
        .loading  (loading),
        .tri_count(tri_count),
        .rd_req   (rd_req),
        .capture  (capture),
        .deliver  (deliver),
        .reject   (reject)
    );

    result_buffer u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .deliver  (deliver),
        .reject   (reject),
        .rdy      (rdy),
        .not_valid(not_valid),
        .tri_out  (tri_out)
    );

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_triangle_store.sv ====
`default_nettype none

module tb_triangle_store;

    timeunit 1ns;
    timeprecision 1ps;

    import tri_pkg::*;

    // about 300 requests at the slowest latency
    localparam int MAX_CYCLES = 4000;
    localparam int WAIT_LIMIT = 40;

    logic       clk;
    logic       rst_n;
    logic       mc_we;
    load_word_u mc_word;
    rd_req_t    rd_req;
    logic       rdy;
    logic       not_valid;
    tri_out_t   tri_out;

    // scene model
    index_rec_t model_idx [NUM_TRIANGLE];
    vertex_t    model_vtx [NUM_VERTEX];
    int         model_count;

    // one entry per outstanding request
    int pend_id [$];
    int pend_cycle [$];
    bit pend_hit [$];
    int cycle_cnt = 0;

    clock_gen u_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    triangle_store dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .mc_we    (mc_we),
        .mc_word  (mc_word),
        .rd_req   (rd_req),
        .rdy      (rdy),
        .tri_out  (tri_out),
        .not_valid(not_valid)
    );

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input string got, input string want);
        $display("** Error at %0t: %s = %s, expected %s", $time, name, got, want);
        fail_run();
    endtask

    // zero return means the id is past the loaded count
    function automatic bit expected_triangle(input int id, output tri_out_t want);
        index_rec_t rec;
        want = '0;
        if (id >= model_count) begin
            return 1'b0;
        end
        rec     = model_idx[id];
        want.sid = rec.sid;
        want.v0  = model_vtx[rec.v0[VERTEX_ADDR_W-1:0]];
        want.v1  = model_vtx[rec.v1[VERTEX_ADDR_W-1:0]];
        want.v2  = model_vtx[rec.v2[VERTEX_ADDR_W-1:0]];
        return 1'b1;
    endfunction

    // junk in the upper bits that the address ignores
    function automatic logic [31:0] pick_vertex(input int nvtx);
        return ($urandom & 32'hffff_f800) | $urandom_range(nvtx - 1, 0);
    endfunction

    task automatic build_scene(input int ntri, input int nvtx);
        model_count = ntri;
        for (int i = 0; i < nvtx; i++) begin
            model_vtx[i].x = $urandom;
            model_vtx[i].y = $urandom;
            model_vtx[i].z = $urandom;
        end
        for (int i = 0; i < ntri; i++) begin
            model_idx[i].sid = $urandom | 32'h1;
            model_idx[i].v0  = pick_vertex(nvtx);
            model_idx[i].v1  = pick_vertex(nvtx);
            model_idx[i].v2  = pick_vertex(nvtx);
        end
    endtask

    // called on a falling edge and returns on the next one
    task automatic send_word(input load_word_u w);
        mc_we   = 1'b1;
        mc_word = w;
        @(negedge clk);
        mc_we   = 1'b0;
    endtask

    task automatic load_scene(input int nvtx);
        load_word_u w;
        for (int i = 0; i < model_count; i++) begin
            w.idx = model_idx[i];
            send_word(w);
        end
        // zero sid closes the index section
        w = '0;
        send_word(w);
        for (int i = 0; i < nvtx; i++) begin
            w.vtx.flag = $urandom | 32'h1;
            w.vtx.pos  = model_vtx[i];
            send_word(w);
        end
        w = '0;
        send_word(w);
        repeat (2) @(negedge clk);
    endtask

    task automatic request(input int id, input bit hit);
        int waited;
        pend_id.push_back(id);
        pend_cycle.push_back(cycle_cnt);
        pend_hit.push_back(hit);
        rd_req.req = 1'b1;
        rd_req.id  = TRI_ID_W'(id);
        @(negedge clk);
        rd_req = '0;
        waited = 1;
        while (!(rdy || not_valid)) begin
            if (waited >= WAIT_LIMIT) begin
                $display("request for triangle %0d got no answer in %0d cycles", id, waited);
                fail_run();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            fail_run();
        end
    end

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        tri_out_t want;
        bit       valid;
        bit       hit;
        int       id;
        int       lat;
        if (rst_n) begin
            if (pend_id.size() == 0) begin
                assert (rdy === 1'b0 && not_valid === 1'b0) else begin
                    $display("answer strobe seen with no request outstanding");
                    fail_run();
                end
            end else if (rdy || not_valid) begin
                id    = pend_id.pop_front();
                lat   = cycle_cnt - pend_cycle.pop_front();
                hit   = pend_hit.pop_front();
                valid = expected_triangle(id, want);
                assert (rdy == valid)
                    else value_error("rdy", $sformatf("%b", rdy), $sformatf("%b", valid));
                assert (not_valid == !valid)
                    else value_error("not_valid", $sformatf("%b", not_valid),
                                     $sformatf("%b", !valid));
                if (valid) begin
                    assert (tri_out == want)
                        else value_error("tri_out", $sformatf("%h", tri_out),
                                         $sformatf("%h", want));
                end
                // range errors and prefetch hits answer in one cycle
                if (!valid || hit) begin
                    assert (lat == 1)
                        else value_error("answer latency", $sformatf("%0d", lat), "1");
                end
            end
        end
    end

    initial begin
        int prev;
        void'($urandom(32'hfff9c112));
        mc_we   = 1'b0;
        mc_word = '0;
        rd_req  = '0;
        wait (rst_n === 1'b1);
        repeat (6) @(negedge clk);

        build_scene(40, 60);
        load_scene(60);

        // sequential walk with gaps long enough for each prefetch to finish
        for (int id = 0; id < model_count; id++) begin
            request(id, id != 0);
            repeat (8) @(negedge clk);
        end

        for (int n = 0; n < 60; n++) begin
            request($urandom_range(model_count + 15, 0), 1'b0);
            repeat ($urandom_range(7, 0)) @(negedge clk);
        end

        // short gaps so requests land on a running prefetch
        prev = 0;
        request(prev, 1'b0);
        for (int n = 0; n < 30; n++) begin
            repeat ($urandom_range(5, 0)) @(negedge clk);
            if (n % 4 == 3 && prev + 1 < model_count) begin
                prev = prev + 1;
            end else begin
                prev = (prev + 2 + $urandom_range(model_count - 4, 0)) % model_count;
            end
            request(prev, 1'b0);
        end

        // second scene with a smaller count
        repeat (4) @(negedge clk);
        build_scene(23, 37);
        load_scene(37);
        for (int n = 0; n < 60; n++) begin
            request($urandom_range(model_count + 17, 0), 1'b0);
            repeat ($urandom_range(7, 0)) @(negedge clk);
        end

        repeat (4) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/tri_pkg.sv
hdl/single_port_ram.sv
hdl/load_decoder.sv
hdl/triangle_fetch.sv
hdl/result_buffer.sv
hdl/triangle_store.sv
test/clock_gen.sv
test/tb_triangle_store.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module tb_triangle_store &&
    ./obj_dir/Vtb_triangle_store | grep -F "Done: no errors" ||
    { echo "simulation failed"; exit 1; }
